/* Makefile */
# Verilator build and run for the soc_lite AHB-Lite subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_lite
FILELIST  ?= soc_lite.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Test completed successfully

SRCS := $(wildcard source/*.sv dv/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(OBJ_DIR)/V%: $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) --Mdir $(OBJ_DIR)

# Passes only if the pass message shows up in the simulation output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/soc_lite_tests.txt */
# opcode address size data: W write, R read and compare, TX send frame, RX receive frame, ERR unmapped
# size 0 byte, 1 half, 2 word; data in hex as it sits on the bus lanes
W 20000000 2 DEADBEEF
W 20000004 2 01234567
R 20000000 2 DEADBEEF
R 20000004 2 01234567
W 20000010 2 11223344
W 20000011 0 0000AA00
W 20000012 1 BBCC0000
W 20000040 2 00000000
R 20000010 2 BBCCAA44
W 20000020 2 55667788
W 20000023 0 99000000
W 20000020 1 0000EEFF
R 20000020 2 9966EEFF
W 20000030 2 CAFEF00D
R 20000030 2 CAFEF00D
W 20000030 0 000000EE
R 20000030 2 CAFEF0EE
TX 40000000 2 000000A5
TX 40000000 2 0000003C
RX 40000000 2 0000005A
RX 40000000 2 000000C3
R 40000004 2 00000000
ERR 60000000 2 00000000
R 20000000 2 DEADBEEF
ERR 20000002 2 00000000
R 20000010 2 BBCCAA44

/* dv/tb_soc_lite.sv */
// Self-checking testbench for soc_lite_top that runs the operations listed in the tests data file
`timescale 1ns/1ps

module tb_soc_lite;

    localparam int    RAM_ADDR_W   = 10;
    localparam int    CLKS_PER_BIT = 8;
    localparam int    FRAME_CLKS   = 10 * CLKS_PER_BIT;    // Start, 8 data, stop
    localparam string TEST_FILE    = "dv/soc_lite_tests.txt";

    logic             clk;
    logic             RSTn;
    soc_pkg::addr_t   haddr;
    soc_pkg::htrans_e htrans;
    soc_pkg::hsize_e  hsize;
    logic             hwrite;
    soc_pkg::data_t   hwdata;
    logic             rxd;
    soc_pkg::data_t   o_hrdata;
    logic             o_hready;
    logic             o_hresp;
    logic             o_txd;
    logic             o_uart_irq;

    // Operations loaded from the data file
    string            op_q[$];
    soc_pkg::addr_t   addr_q[$];
    soc_pkg::hsize_e  size_q[$];
    soc_pkg::data_t   data_q[$];
    int               n_tests;

    soc_lite_top #(.RAM_ADDR_W(RAM_ADDR_W), .CLKS_PER_BIT(CLKS_PER_BIT)) u_soc_lite_top
    (
        .clk        (clk),
        .RSTn       (RSTn),
        .i_haddr    (haddr),
        .i_htrans   (htrans),
        .i_hsize    (hsize),
        .i_hwrite   (hwrite),
        .i_hwdata   (hwdata),
        .i_rxd      (rxd),
        .o_hrdata   (o_hrdata),
        .o_hready   (o_hready),
        .o_hresp    (o_hresp),
        .o_txd      (o_txd),
        .o_uart_irq (o_uart_irq)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;     // 8 ns period
    end

    //------------------------------------------------------------
    // Error handling and checking
    //------------------------------------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input soc_pkg::data_t actual,
                               input soc_pkg::data_t expected);
        if (actual !== expected)
            fail_run($sformatf("FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected));
    endtask

    // Watchdog sized from the number of operations
    initial
    begin
        wait (n_tests > 0);
        repeat (n_tests * 12 * FRAME_CLKS + 1000) @(posedge clk);
        fail_run("Timeout: the tests did not finish in the allowed time");
    end

    task automatic load_tests;
        int             fd;
        int             n;
        string          line;
        string          op;
        logic [31:0]    a;
        logic [31:0]    s;
        logic [31:0]    d;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0)
            fail_run("Could not open the tests data file");
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                n    = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line.getc(0) != "#")    // Skip comments
                begin
                    n = $sscanf(line, "%s %h %h %h", op, a, s, d);
                    if (n != 4)
                        fail_run({"Malformed line in the tests data file: ", line});
                    else
                    begin
                        op_q.push_back(op);
                        addr_q.push_back(a);
                        size_q.push_back(soc_pkg::hsize_e'(s[2:0]));
                        data_q.push_back(d);
                    end
                end
            end
            $fclose(fd);
            n_tests = op_q.size();
        end
    endtask

    //------------------------------------------------------------
    // AHB-Lite master
    //------------------------------------------------------------
    task automatic wait_ready;
        int guard;
        guard = 0;
        @(negedge clk);
        while (!o_hready)
        begin
            guard++;
            if (guard > 16)
                fail_run("o_hready stayed low for too long");
            else
                @(negedge clk);
        end
    endtask

    task automatic addr_phase(input soc_pkg::addr_t a, input soc_pkg::hsize_e s, input logic wr);
        @(posedge clk);
        haddr  <= a;
        hsize  <= s;
        hwrite <= wr;
        htrans <= soc_pkg::NONSEQ;
    endtask

    task automatic ahb_write(input soc_pkg::addr_t a, input soc_pkg::hsize_e s,
                             input soc_pkg::data_t d);
        addr_phase(a, s, 1'b1);
        wait_ready();
        @(posedge clk);
        htrans <= soc_pkg::IDLE;
        hwrite <= 1'b0;
        hwdata <= d;
        wait_ready();
        check_value("o_hresp write", {31'b0, o_hresp}, 32'h0);
    endtask

    task automatic ahb_read(input soc_pkg::addr_t a, input soc_pkg::hsize_e s,
                            output soc_pkg::data_t rd);
        addr_phase(a, s, 1'b0);
        wait_ready();
        @(posedge clk);
        htrans <= soc_pkg::IDLE;
        wait_ready();
        rd = o_hrdata;
        check_value("o_hresp read", {31'b0, o_hresp}, 32'h0);
    endtask

    // Read address phase overlaps the write data phase
    task automatic ahb_write_read(input soc_pkg::addr_t wa, input soc_pkg::hsize_e ws,
                                  input soc_pkg::data_t wd, input soc_pkg::addr_t ra,
                                  input soc_pkg::hsize_e rs, output soc_pkg::data_t rd);
        addr_phase(wa, ws, 1'b1);
        wait_ready();
        @(posedge clk);
        hwdata <= wd;
        haddr  <= ra;
        hsize  <= rs;
        hwrite <= 1'b0;
        htrans <= soc_pkg::NONSEQ;
        wait_ready();
        check_value("o_hresp write", {31'b0, o_hresp}, 32'h0);
        @(posedge clk);
        htrans <= soc_pkg::IDLE;
        wait_ready();
        rd = o_hrdata;
        check_value("o_hresp read", {31'b0, o_hresp}, 32'h0);
    endtask

    //------------------------------------------------------------
    // UART line driver and monitor
    //------------------------------------------------------------
    task automatic drive_rx_frame(input logic [7:0] value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};   // LSB first after the start bit
        for (int b = 0; b < 10; b++)
        begin
            @(posedge clk);
            rxd <= frame[b];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic monitor_tx(output logic [7:0] value);
        int guard;
        guard = 0;
        @(negedge clk);
        while (o_txd)
        begin
            guard++;
            if (guard > 2)
                fail_run("o_txd did not fall within 2 cycles after the UART DATA write");
            else
                @(negedge clk);
        end
        repeat (CLKS_PER_BIT / 2) @(negedge clk);     // Middle of the start bit
        check_value("o_txd start bit", {31'b0, o_txd}, 32'h0);
        for (int b = 0; b < 8; b++)
        begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            value[b] = o_txd;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        check_value("o_txd stop bit", {31'b0, o_txd}, 32'h1);
    endtask

    task automatic wait_irq;
        int guard;
        guard = 0;
        @(negedge clk);
        while (!o_uart_irq)
        begin
            guard++;
            if (guard > 2 * FRAME_CLKS)
                fail_run("o_uart_irq did not rise within two frame lengths");
            else
                @(negedge clk);
        end
    endtask

    //------------------------------------------------------------
    // Operations
    //------------------------------------------------------------
    task automatic run_tx(input soc_pkg::addr_t a, input soc_pkg::data_t d);
        soc_pkg::addr_t stat_addr;
        soc_pkg::data_t stat;
        logic [7:0]     seen;
        stat_addr = {a[31:4], soc_pkg::UART_STAT_OFS};
        ahb_write(a, soc_pkg::WORD, d);
        fork
            monitor_tx(seen);
            begin
                ahb_read(stat_addr, soc_pkg::WORD, stat);
                check_value("o_hrdata STATUS busy during frame", {31'b0, stat[0]}, 32'h1);
            end
        join
        check_value("o_txd frame byte", {24'b0, seen}, {24'b0, d[7:0]});
        repeat (CLKS_PER_BIT / 2) @(negedge clk);    // Past the end of the stop bit
        ahb_read(stat_addr, soc_pkg::WORD, stat);
        check_value("o_hrdata STATUS busy after frame", {31'b0, stat[0]}, 32'h0);
    endtask

    task automatic run_rx(input soc_pkg::addr_t a, input soc_pkg::data_t d);
        soc_pkg::data_t rd;
        fork
            drive_rx_frame(d[7:0]);
            wait_irq();
        join
        ahb_read(a, soc_pkg::WORD, rd);
        check_value("o_hrdata received byte", rd, {24'b0, d[7:0]});
        @(negedge clk);
        check_value("o_uart_irq after DATA read", {31'b0, o_uart_irq}, 32'h0);
    endtask

    task automatic run_err(input soc_pkg::addr_t a, input soc_pkg::hsize_e s);
        addr_phase(a, s, 1'b0);
        wait_ready();
        @(posedge clk);
        htrans <= soc_pkg::IDLE;
        @(negedge clk);
        check_value("o_hready error cycle 1", {31'b0, o_hready}, 32'h0);
        check_value("o_hresp error cycle 1", {31'b0, o_hresp}, 32'h1);
        @(negedge clk);
        check_value("o_hready error cycle 2", {31'b0, o_hready}, 32'h1);
        check_value("o_hresp error cycle 2", {31'b0, o_hresp}, 32'h1);
    endtask

    task automatic run_line(input int i);
        soc_pkg::data_t rd;
        if (op_q[i] == "W")
            ahb_write(addr_q[i], size_q[i], data_q[i]);
        else if (op_q[i] == "R")
        begin
            ahb_read(addr_q[i], size_q[i], rd);
            check_value("o_hrdata", rd, data_q[i]);
        end
        else if (op_q[i] == "TX")
            run_tx(addr_q[i], data_q[i]);
        else if (op_q[i] == "RX")
            run_rx(addr_q[i], data_q[i]);
        else if (op_q[i] == "ERR")
            run_err(addr_q[i], size_q[i]);
        else
            fail_run({"Unknown opcode in the tests data file: ", op_q[i]});
    endtask

    //------------------------------------------------------------
    // Main sequence
    //------------------------------------------------------------
    initial
    begin
        int             idx;
        soc_pkg::data_t rd;
        RSTn   = 1'b0;
        haddr  = '0;
        htrans = soc_pkg::IDLE;
        hsize  = soc_pkg::WORD;
        hwrite = 1'b0;
        hwdata = '0;
        rxd    = 1'b1;     // Idle line
        load_tests();
        repeat (3) @(posedge clk);     // 2 full cycles after the first edge
        RSTn <= 1'b1;
        @(negedge clk);
        check_value("o_hready after reset", {31'b0, o_hready}, 32'h1);
        check_value("o_hresp after reset", {31'b0, o_hresp}, 32'h0);
        check_value("o_txd after reset", {31'b0, o_txd}, 32'h1);
        check_value("o_uart_irq after reset", {31'b0, o_uart_irq}, 32'h0);
        idx = 0;
        while (idx < n_tests)
        begin
            if (op_q[idx] == "W" && idx + 1 < n_tests && op_q[idx + 1] == "R")
            begin
                ahb_write_read(addr_q[idx], size_q[idx], data_q[idx],
                               addr_q[idx + 1], size_q[idx + 1], rd);
                check_value("o_hrdata pipelined", rd, data_q[idx + 1]);
                idx = idx + 2;
            end
            else
            begin
                run_line(idx);
                idx = idx + 1;
            end
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* soc_lite.f */
source/soc_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/ahb_sram.sv
source/ahb_uart.sv
source/ahb_interconnect.sv
source/soc_lite_top.sv
dv/tb_soc_lite.sv

/* source/ahb_interconnect.sv */
// AHB-Lite decoder and response mux, with a default slave that answers unmapped or bad transfers
`timescale 1ns/1ps

module ahb_interconnect
(
    input  logic             clk,
    input  logic             RSTn,
    input  soc_pkg::addr_t   i_haddr,
    input  soc_pkg::htrans_e i_htrans,
    input  soc_pkg::hsize_e  i_hsize,
    input  logic             i_sram_hreadyout,
    input  logic             i_sram_hresp,
    input  soc_pkg::data_t   i_sram_hrdata,
    input  logic             i_uart_hreadyout,
    input  logic             i_uart_hresp,
    input  soc_pkg::data_t   i_uart_hrdata,
    output logic             o_hsel_sram,
    output logic             o_hsel_uart,
    output logic             o_hready,
    output logic             o_hresp,
    output soc_pkg::data_t   o_hrdata
);

    typedef enum logic {ERR_FIRST, ERR_LAST} err_e;

    soc_pkg::slave_e dec_slv;
    soc_pkg::slave_e data_slv_q;    // Target of the transfer now in its data phase
    err_e            err_q;
    logic            accept;
    logic            misaligned;

    //------------------------------------------------------------
    // Address phase decode
    //------------------------------------------------------------
    assign misaligned = ((i_hsize == soc_pkg::HALF) && i_haddr[0]) ||
                        ((i_hsize == soc_pkg::WORD) && (i_haddr[1:0] != 2'b00));

    always_comb
    begin
        if (misaligned || (i_hsize > soc_pkg::WORD))
            dec_slv = soc_pkg::SLV_NONE;
        else if (i_haddr[soc_pkg::REGION_MSB -: 4] ==
                 soc_pkg::SRAM_BASE[soc_pkg::REGION_MSB -: 4])
            dec_slv = soc_pkg::SLV_SRAM;
        else if (i_haddr[soc_pkg::REGION_MSB -: 4] ==
                 soc_pkg::UART_BASE[soc_pkg::REGION_MSB -: 4])
            dec_slv = soc_pkg::SLV_UART;
        else
            dec_slv = soc_pkg::SLV_NONE;
    end

    assign o_hsel_sram = (dec_slv == soc_pkg::SLV_SRAM);
    assign o_hsel_uart = (dec_slv == soc_pkg::SLV_UART);
    assign accept      = o_hready &&
                         ((i_htrans == soc_pkg::NONSEQ) || (i_htrans == soc_pkg::SEQ));

    // An idle data phase is routed to the RAM, which always answers OKAY
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
            data_slv_q <= soc_pkg::SLV_SRAM;
        else if (o_hready)
            data_slv_q <= accept ? dec_slv : soc_pkg::SLV_SRAM;
    end

    // Two-cycle error response
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
            err_q <= ERR_FIRST;
        else if (data_slv_q == soc_pkg::SLV_NONE)
            err_q <= (err_q == ERR_FIRST) ? ERR_LAST : ERR_FIRST;
    end

    //------------------------------------------------------------
    // Data phase response mux
    //------------------------------------------------------------
    always_comb
    begin
        case (data_slv_q)
            soc_pkg::SLV_UART:
            begin
                o_hready = i_uart_hreadyout;
                o_hresp  = i_uart_hresp;
                o_hrdata = i_uart_hrdata;
            end
            soc_pkg::SLV_NONE:
            begin
                o_hready = (err_q == ERR_LAST);     // Low, then high
                o_hresp  = 1'b1;
                o_hrdata = '0;
            end
            default:
            begin
                o_hready = i_sram_hreadyout;
                o_hresp  = i_sram_hresp;
                o_hrdata = i_sram_hrdata;
            end
        endcase
    end

endmodule

/* source/ahb_sram.sv */
// AHB-Lite data RAM slave, zero wait states, byte-lane writes and forwarding of an in-flight write
`timescale 1ns/1ps

module ahb_sram
#(
    parameter int RAM_ADDR_W = 10
)
(
    input  logic             clk,
    input  logic             RSTn,
    input  logic             i_hsel,
    input  soc_pkg::addr_t   i_haddr,
    input  soc_pkg::htrans_e i_htrans,
    input  soc_pkg::hsize_e  i_hsize,
    input  logic             i_hwrite,
    input  soc_pkg::data_t   i_hwdata,
    input  logic             i_hready,
    output logic             o_hreadyout,
    output logic             o_hresp,
    output soc_pkg::data_t   o_hrdata
);

    soc_pkg::data_t          mem [2**RAM_ADDR_W];

    logic                    accept;
    logic [RAM_ADDR_W-1:0]   word_addr;
    logic                    wr_pend_q;     // Write waiting for its data phase
    logic [RAM_ADDR_W-1:0]   wr_addr_q;
    logic [3:0]              wr_mask_q;
    logic [3:0]              fwd_mask_q;    // Lanes taken from the forwarded write
    soc_pkg::data_t          fwd_data_q;
    soc_pkg::data_t          rd_data_q;

    function automatic logic [3:0] lane_mask(input soc_pkg::hsize_e size, input logic [1:0] ofs);
        case (size)
            soc_pkg::BYTE: lane_mask = 4'b0001 << ofs;
            soc_pkg::HALF: lane_mask = ofs[1] ? 4'b1100 : 4'b0011;
            default:       lane_mask = 4'b1111;
        endcase
    endfunction

    assign accept    = i_hsel && i_hready &&
                       ((i_htrans == soc_pkg::NONSEQ) || (i_htrans == soc_pkg::SEQ));
    assign word_addr = i_haddr[RAM_ADDR_W+1:2];

    //------------------------------------------------------------
    // Address phase control
    //------------------------------------------------------------
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            wr_pend_q  <= 1'b0;
            fwd_mask_q <= 4'b0;
        end
        else if (i_hready)
        begin
            wr_pend_q <= accept && i_hwrite;
            if (accept && !i_hwrite)    // Read hits the word being written right now
                fwd_mask_q <= (wr_pend_q && (wr_addr_q == word_addr)) ? wr_mask_q : 4'b0;
        end
    end

    //------------------------------------------------------------
    // RAM array and read port
    //------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            wr_addr_q <= word_addr;
            wr_mask_q <= lane_mask(i_hsize, i_haddr[1:0]);
        end
        if (wr_pend_q && i_hready)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (wr_mask_q[b])
                    mem[wr_addr_q][8*b +: 8] <= i_hwdata[8*b +: 8];
            end
        end
        if (accept && !i_hwrite)
        begin
            rd_data_q  <= mem[word_addr];
            fwd_data_q <= i_hwdata;     // Write data of the overlapping data phase
        end
    end

    always_comb
    begin
        for (int b = 0; b < 4; b++)
            o_hrdata[8*b +: 8] = fwd_mask_q[b] ? fwd_data_q[8*b +: 8] : rd_data_q[8*b +: 8];
    end

    assign o_hreadyout = 1'b1;  // No wait states
    assign o_hresp     = 1'b0;

endmodule

/* source/ahb_uart.sv */
// AHB-Lite UART register block with DATA and STATUS registers and a receive interrupt
`timescale 1ns/1ps

module ahb_uart
#(
    parameter int CLKS_PER_BIT = 8
)
(
    input  logic             clk,
    input  logic             RSTn,
    input  logic             i_hsel,
    input  soc_pkg::addr_t   i_haddr,
    input  soc_pkg::htrans_e i_htrans,
    input  logic             i_hwrite,
    input  soc_pkg::data_t   i_hwdata,
    input  logic             i_hready,
    input  logic             i_rxd,
    output logic             o_hreadyout,
    output logic             o_hresp,
    output soc_pkg::data_t   o_hrdata,
    output logic             o_txd,
    output logic             o_irq
);

    logic                            acc_q;     // Data phase belongs to this slave
    logic                            wr_q;
    logic [3:0]                      ofs_q;
    logic                            tx_start;
    logic                            tx_busy;
    logic                            rx_done;
    logic [soc_pkg::UART_BYTE_W-1:0] rx_data;
    logic [soc_pkg::UART_BYTE_W-1:0] rx_byte_q;
    logic                            rx_valid_q;
    logic                            data_rd;

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            acc_q <= 1'b0;
            wr_q  <= 1'b0;
            ofs_q <= 4'h0;
        end
        else if (i_hready)
        begin
            acc_q <= i_hsel &&
                     ((i_htrans == soc_pkg::NONSEQ) || (i_htrans == soc_pkg::SEQ));
            wr_q  <= i_hwrite;
            ofs_q <= i_haddr[3:0];
        end
    end

    //------------------------------------------------------------
    // Data phase actions
    //------------------------------------------------------------
    assign tx_start = acc_q && wr_q && i_hready && (ofs_q == soc_pkg::UART_DATA_OFS);
    assign data_rd  = acc_q && !wr_q && i_hready && (ofs_q == soc_pkg::UART_DATA_OFS);

    // A new byte wins over a read in the same cycle
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
            rx_valid_q <= 1'b0;
        else if (rx_done)
            rx_valid_q <= 1'b1;
        else if (data_rd)
            rx_valid_q <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (rx_done)
            rx_byte_q <= rx_data;
    end

    always_comb
    begin
        case (ofs_q)
            soc_pkg::UART_DATA_OFS: o_hrdata = {24'b0, rx_byte_q};
            soc_pkg::UART_STAT_OFS: o_hrdata = {30'b0, rx_valid_q, tx_busy};
            default:                o_hrdata = '0;
        endcase
    end

    assign o_irq       = rx_valid_q;
    assign o_hreadyout = 1'b1;
    assign o_hresp     = 1'b0;

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx
    (
        .clk     (clk),
        .RSTn    (RSTn),
        .i_start (tx_start),
        .i_data  (i_hwdata[soc_pkg::UART_BYTE_W-1:0]),
        .o_txd   (o_txd),
        .o_busy  (tx_busy)
    );

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx
    (
        .clk     (clk),
        .RSTn    (RSTn),
        .i_rxd   (i_rxd),
        .o_data  (rx_data),
        .o_done  (rx_done)
    );

endmodule

/* source/soc_lite_top.sv */
// Top level of the soc_lite AHB-Lite subsystem, connects the interconnect, data RAM and UART
`timescale 1ns/1ps

module soc_lite_top
#(
    parameter int RAM_ADDR_W   = 10,
    parameter int CLKS_PER_BIT = 8
)
(
    input  logic             clk,
    input  logic             RSTn,
    input  soc_pkg::addr_t   i_haddr,
    input  soc_pkg::htrans_e i_htrans,
    input  soc_pkg::hsize_e  i_hsize,
    input  logic             i_hwrite,
    input  soc_pkg::data_t   i_hwdata,
    input  logic             i_rxd,
    output soc_pkg::data_t   o_hrdata,
    output logic             o_hready,
    output logic             o_hresp,
    output logic             o_txd,
    output logic             o_uart_irq
);

    logic           hsel_sram;
    logic           hsel_uart;
    logic           hready_in;      // Combined ready, seen by both slaves
    logic           sram_hreadyout;
    logic           sram_hresp;
    soc_pkg::data_t sram_hrdata;
    logic           uart_hreadyout;
    logic           uart_hresp;
    soc_pkg::data_t uart_hrdata;

    assign o_hready = hready_in;

    ahb_interconnect u_ahb_interconnect
    (
        .clk              (clk),
        .RSTn             (RSTn),
        .i_haddr          (i_haddr),
        .i_htrans         (i_htrans),
        .i_hsize          (i_hsize),
        .i_sram_hreadyout (sram_hreadyout),
        .i_sram_hresp     (sram_hresp),
        .i_sram_hrdata    (sram_hrdata),
        .i_uart_hreadyout (uart_hreadyout),
        .i_uart_hresp     (uart_hresp),
        .i_uart_hrdata    (uart_hrdata),
        .o_hsel_sram      (hsel_sram),
        .o_hsel_uart      (hsel_uart),
        .o_hready         (hready_in),
        .o_hresp          (o_hresp),
        .o_hrdata         (o_hrdata)
    );

    ahb_sram #(.RAM_ADDR_W(RAM_ADDR_W)) u_ahb_sram
    (
        .clk         (clk),
        .RSTn        (RSTn),
        .i_hsel      (hsel_sram),
        .i_haddr     (i_haddr),
        .i_htrans    (i_htrans),
        .i_hsize     (i_hsize),
        .i_hwrite    (i_hwrite),
        .i_hwdata    (i_hwdata),
        .i_hready    (hready_in),
        .o_hreadyout (sram_hreadyout),
        .o_hresp     (sram_hresp),
        .o_hrdata    (sram_hrdata)
    );

    ahb_uart #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_ahb_uart
    (
        .clk         (clk),
        .RSTn        (RSTn),
        .i_hsel      (hsel_uart),
        .i_haddr     (i_haddr),
        .i_htrans    (i_htrans),
        .i_hwrite    (i_hwrite),
        .i_hwdata    (i_hwdata),
        .i_hready    (hready_in),
        .i_rxd       (i_rxd),
        .o_hreadyout (uart_hreadyout),
        .o_hresp     (uart_hresp),
        .o_hrdata    (uart_hrdata),
        .o_txd       (o_txd),
        .o_irq       (o_uart_irq)
    );

endmodule

/* source/soc_pkg.sv */
// Bus types, transfer encodings, address map and UART register offsets for the soc_lite subsystem
package soc_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // AHB-Lite transfer type
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    // AHB-Lite transfer size, byte to word only
    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_e;

    typedef enum logic [1:0] {
        SLV_SRAM = 2'd0,
        SLV_UART = 2'd1,
        SLV_NONE = 2'd2     // Default slave, error response
    } slave_e;

    //------------------------------------------------------------
    // Address map
    //------------------------------------------------------------
    localparam addr_t      SRAM_BASE  = 32'h2000_0000;
    localparam addr_t      UART_BASE  = 32'h4000_0000;
    localparam logic [4:0] REGION_MSB = 5'd31;  // Top nibble picks the region

    localparam logic [3:0] UART_DATA_OFS = 4'h0;
    localparam logic [3:0] UART_STAT_OFS = 4'h4;
    localparam int         UART_BYTE_W   = 8;

endpackage

/* source/uart_rx.sv */
// UART receiver, 8N1 frame sampled at mid-bit, one-cycle done pulse on a valid stop bit
`timescale 1ns/1ps

module uart_rx
#(
    parameter int CLKS_PER_BIT = 8
)
(
    input  logic       clk,
    input  logic       RSTn,
    input  logic       i_rxd,
    output logic [7:0] o_data,
    output logic       o_done
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int HALF  = CLKS_PER_BIT / 2;

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_e;

    state_e           state_q;
    logic             rxd_meta_q;
    logic             rxd_sync_q;
    logic             rxd_prev_q;
    logic [CNT_W-1:0] cnt_q;
    logic [2:0]       bit_idx_q;
    logic [7:0]       shift_q;
    logic             bit_end;

    assign bit_end = (cnt_q == CNT_W'(CLKS_PER_BIT - 1));

    //------------------------------------------------------------
    // Input synchronizer
    //------------------------------------------------------------
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            rxd_meta_q <= 1'b1;
            rxd_sync_q <= 1'b1;
            rxd_prev_q <= 1'b1;
        end
        else
        begin
            rxd_meta_q <= i_rxd;
            rxd_sync_q <= rxd_meta_q;
            rxd_prev_q <= rxd_sync_q;   // For the falling edge
        end
    end

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            state_q   <= IDLE;
            cnt_q     <= '0;
            bit_idx_q <= 3'd0;
            shift_q   <= 8'h00;
            o_done    <= 1'b0;
        end
        else
        begin
            o_done <= 1'b0;
            cnt_q  <= cnt_q + 1'b1;
            case (state_q)
                IDLE:
                begin
                    cnt_q <= '0;
                    if (rxd_prev_q && !rxd_sync_q)
                        state_q <= START;
                end
                START:
                    if (cnt_q == CNT_W'(HALF - 1))  // Middle of the start bit
                    begin
                        cnt_q     <= '0;
                        bit_idx_q <= 3'd0;
                        state_q   <= rxd_sync_q ? IDLE : DATA;  // Glitch, back to idle
                    end
                DATA:
                    if (bit_end)
                    begin
                        cnt_q     <= '0;
                        shift_q   <= {rxd_sync_q, shift_q[7:1]};
                        bit_idx_q <= bit_idx_q + 1'b1;
                        if (bit_idx_q == 3'd7)
                            state_q <= STOP;
                    end
                default:
                    if (bit_end)
                    begin
                        o_done  <= rxd_sync_q;  // Low stop bit drops the frame
                        state_q <= IDLE;
                    end
            endcase
        end
    end

    assign o_data = shift_q;

endmodule

/* source/uart_tx.sv */
// UART transmitter, 8N1 frame with its own bit-period counter, start ignored while busy
`timescale 1ns/1ps

module uart_tx
#(
    parameter int CLKS_PER_BIT = 8
)
(
    input  logic       clk,
    input  logic       RSTn,
    input  logic       i_start,
    input  logic [7:0] i_data,
    output logic       o_txd,
    output logic       o_busy
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_e;

    state_e           state_q;
    logic [CNT_W-1:0] cnt_q;
    logic [2:0]       bit_idx_q;
    logic [7:0]       shift_q;
    logic             bit_end;

    assign bit_end = (cnt_q == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            state_q   <= IDLE;
            cnt_q     <= '0;
            bit_idx_q <= 3'd0;
            shift_q   <= 8'h00;
            o_txd     <= 1'b1;  // Idle line
        end
        else
        begin
            cnt_q <= (state_q == IDLE || bit_end) ? '0 : cnt_q + 1'b1;
            case (state_q)
                IDLE:
                    if (i_start)
                    begin
                        state_q <= START;
                        shift_q <= i_data;
                        o_txd   <= 1'b0;
                    end
                START:
                    if (bit_end)
                    begin
                        state_q   <= DATA;
                        bit_idx_q <= 3'd0;
                        o_txd     <= shift_q[0];    // LSB first
                        shift_q   <= shift_q >> 1;
                    end
                DATA:
                    if (bit_end)
                    begin
                        if (bit_idx_q == 3'd7)
                        begin
                            state_q <= STOP;
                            o_txd   <= 1'b1;
                        end
                        else
                        begin
                            bit_idx_q <= bit_idx_q + 1'b1;
                            o_txd     <= shift_q[0];
                            shift_q   <= shift_q >> 1;
                        end
                    end
                default:
                    if (bit_end)
                        state_q <= IDLE;
            endcase
        end
    end

    assign o_busy = (state_q != IDLE);

endmodule
